// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int INST_W = 32;

    // Major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI      = 7'b011_0111,
        OP_AUIPC    = 7'b001_0111,
        OP_JAL      = 7'b110_1111,
        OP_JALR     = 7'b110_0111,
        OP_BRANCH   = 7'b110_0011,
        OP_LOAD     = 7'b000_0011,
        OP_STORE    = 7'b010_0011,
        OP_OP_IMM   = 7'b001_0011,
        OP_OP       = 7'b011_0011,
        OP_IMM_32   = 7'b001_1011,
        OP_OP_32    = 7'b011_1011,
        OP_MISC_MEM = 7'b000_1111,
        OP_SYSTEM   = 7'b111_0011
    } opcode_e;

    // Arithmetic funct3 for OP, OP_IMM and the word classes
    typedef enum logic [2:0] {
        F3OP_ADD_SUB = 3'b000,
        F3OP_SLL     = 3'b001,
        F3OP_SLT     = 3'b010,
        F3OP_SLTU    = 3'b011,
        F3OP_XOR     = 3'b100,
        F3OP_SRX     = 3'b101,
        F3OP_OR      = 3'b110,
        F3OP_AND     = 3'b111
    } funct3_op_e;

    // Legal funct7 values; bit 5 selects sub and arithmetic shift
    localparam logic [6:0] F7_BASE = 7'b000_0000;
    localparam logic [6:0] F7_ALT  = 7'b010_0000;

    // Upper six bits of a 64-bit shift immediate
    localparam logic [5:0] F6_BASE = 6'b00_0000;
    localparam logic [5:0] F6_ALT  = 6'b01_0000;

endpackage

// File: exec_pkg.sv
package exec_pkg;

    localparam int XLEN = 64;
    localparam int WORD_W = 32;

    // Register index width fixed by the instruction format
    localparam int REG_IDX_W = 5;

    localparam int SHAMT_W = 6;
    localparam int WORD_SHAMT_W = 5;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // Operand b straight through for LUI
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

// File: rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder #(
    parameter int REG_COUNT = 32
) (
    input  logic [rv_isa_pkg::INST_W-1:0]   inst,
    output logic [exec_pkg::REG_IDX_W-1:0]  rs1_idx,
    output logic [exec_pkg::REG_IDX_W-1:0]  rs2_idx,
    output logic [exec_pkg::REG_IDX_W-1:0]  rd_idx,
    output logic [exec_pkg::XLEN-1:0]       imm,
    output logic                            use_imm,
    output logic                            word_op,
    output exec_pkg::alu_op_e               alu_op,
    output logic                            illegal_inst
);
    import rv_isa_pkg::*;
    import exec_pkg::*;

    opcode_e          opcode;
    funct3_op_e       funct3;
    logic [6:0]       funct7;
    logic [XLEN-1:0]  imm_i;
    logic [XLEN-1:0]  imm_u;
    logic             f7_ok;
    logic             bad_enc;
    logic             uses_rs2;
    logic             idx_bad;

    function automatic alu_op_e map_op(input funct3_op_e f3, input logic alt);
        case (f3)
            F3OP_ADD_SUB: map_op = alt ? ALU_SUB : ALU_ADD;
            F3OP_SLL:     map_op = ALU_SLL;
            F3OP_SLT:     map_op = ALU_SLT;
            F3OP_SLTU:    map_op = ALU_SLTU;
            F3OP_XOR:     map_op = ALU_XOR;
            F3OP_SRX:     map_op = alt ? ALU_SRA : ALU_SRL;
            F3OP_OR:      map_op = ALU_OR;
            default:      map_op = ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = funct3_op_e'(inst[14:12]);
    assign funct7 = inst[31:25];
    assign imm_i  = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_u  = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};

    // Alt form only for sub and the arithmetic right shifts
    assign f7_ok = (funct7 == F7_BASE) ||
                   (funct7 == F7_ALT && (funct3 == F3OP_ADD_SUB || funct3 == F3OP_SRX));

    always_comb begin
        rs1_idx  = inst[19:15];
        rs2_idx  = inst[24:20];
        rd_idx   = inst[11:7];
        imm      = imm_i;
        use_imm  = 1'b1;
        word_op  = 1'b0;
        uses_rs2 = 1'b0;
        bad_enc  = 1'b0;
        alu_op   = ALU_ADD;
        case (opcode)
            OP_LUI: begin
                rs1_idx = '0;
                imm     = imm_u;
                alu_op  = ALU_PASS_B;
            end
            OP_OP_IMM: begin
                alu_op = map_op(funct3, funct3 == F3OP_SRX && inst[30]);
                if (funct3 == F3OP_SLL) begin
                    bad_enc = inst[31:26] != F6_BASE;
                end else if (funct3 == F3OP_SRX) begin
                    bad_enc = inst[31:26] != F6_BASE && inst[31:26] != F6_ALT;
                end
            end
            OP_IMM_32: begin
                word_op = 1'b1;
                alu_op  = map_op(funct3, funct3 == F3OP_SRX && inst[30]);
                if (funct3 == F3OP_SLL || funct3 == F3OP_SRX) begin
                    bad_enc = !f7_ok;
                end else begin
                    bad_enc = funct3 != F3OP_ADD_SUB;
                end
            end
            OP_OP, OP_OP_32: begin
                use_imm  = 1'b0;
                uses_rs2 = 1'b1;
                word_op  = opcode == OP_OP_32;
                alu_op   = map_op(funct3, funct7 == F7_ALT);
                bad_enc  = !f7_ok;
                if (opcode == OP_OP_32 && funct3 != F3OP_ADD_SUB &&
                    funct3 != F3OP_SLL && funct3 != F3OP_SRX) begin
                    bad_enc = 1'b1;
                end
            end
            default: bad_enc = 1'b1;
        endcase
    end

    // Only matters for the reduced register file
    assign idx_bad = int'(rd_idx) >= REG_COUNT || int'(rs1_idx) >= REG_COUNT ||
                     (uses_rs2 && int'(rs2_idx) >= REG_COUNT);

    assign illegal_inst = bad_enc || idx_bad;

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [exec_pkg::XLEN-1:0] a,
    input  logic [exec_pkg::XLEN-1:0] b,
    input  exec_pkg::alu_op_e         alu_op,
    input  logic                      word_op,
    output logic [exec_pkg::XLEN-1:0] result
);
    import exec_pkg::*;

    logic [XLEN-1:0]         res64;
    logic [WORD_W-1:0]       res32;
    logic [WORD_W-1:0]       a32;
    logic [WORD_W-1:0]       b32;
    logic [SHAMT_W-1:0]      shamt;
    logic [WORD_SHAMT_W-1:0] shamt32;

    assign a32     = a[WORD_W-1:0];
    assign b32     = b[WORD_W-1:0];
    assign shamt   = b[SHAMT_W-1:0];
    assign shamt32 = b[WORD_SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    res64 = a + b;
            ALU_SUB:    res64 = a - b;
            ALU_SLL:    res64 = a << shamt;
            ALU_SLT:    res64 = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   res64 = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:    res64 = a ^ b;
            ALU_SRL:    res64 = a >> shamt;
            ALU_SRA:    res64 = $unsigned($signed(a) >>> shamt);
            ALU_OR:     res64 = a | b;
            ALU_AND:    res64 = a & b;
            ALU_PASS_B: res64 = b;
            default:    res64 = '0;
        endcase
    end

    // Word forms only exist for add, sub and the shifts
    always_comb begin
        case (alu_op)
            ALU_ADD: res32 = a32 + b32;
            ALU_SUB: res32 = a32 - b32;
            ALU_SLL: res32 = a32 << shamt32;
            ALU_SRL: res32 = a32 >> shamt32;
            ALU_SRA: res32 = $unsigned($signed(a32) >>> shamt32);
            default: res32 = res64[WORD_W-1:0];
        endcase
    end

    assign result = word_op ? {{(XLEN-WORD_W){res32[WORD_W-1]}}, res32} : res64;

endmodule

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [exec_pkg::REG_IDX_W-1:0] rs1_idx,
    input  logic [exec_pkg::REG_IDX_W-1:0] rs2_idx,
    output logic [exec_pkg::XLEN-1:0]      rs1_data,
    output logic [exec_pkg::XLEN-1:0]      rs2_data,
    input  logic                           wr_en,
    input  logic [exec_pkg::REG_IDX_W-1:0] wr_idx,
    input  logic [exec_pkg::XLEN-1:0]      wr_data
);
    import exec_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0 && int'(wr_idx) < REG_COUNT) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 and out of range indices read as zero
    assign rs1_data = (rs1_idx != '0 && int'(rs1_idx) < REG_COUNT) ? regs[rs1_idx] : '0;
    assign rs2_data = (rs2_idx != '0 && int'(rs2_idx) < REG_COUNT) ? regs[rs2_idx] : '0;

endmodule

// File: rv_exec_unit.sv
`timescale 1ns/1ns

module rv_exec_unit #(
    parameter int REG_COUNT = 32
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           inst_valid,
    input  logic [rv_isa_pkg::INST_W-1:0]  inst,
    output logic                           result_valid,
    output logic                           illegal,
    output logic [exec_pkg::REG_IDX_W-1:0] result_rd,
    output logic [exec_pkg::XLEN-1:0]      result
);
    import exec_pkg::*;

    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      imm;
    logic                 use_imm;
    logic                 word_op;
    alu_op_e              alu_op;
    logic                 illegal_inst;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      op_b;
    logic [XLEN-1:0]      alu_result;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] wr_idx;
    logic [XLEN-1:0]      wr_data;

    rv_decoder #(
        .REG_COUNT(REG_COUNT)
    ) u_rv_decoder (
        .inst        (inst),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_idx      (rd_idx),
        .imm         (imm),
        .use_imm     (use_imm),
        .word_op     (word_op),
        .alu_op      (alu_op),
        .illegal_inst(illegal_inst)
    );

    reg_file #(
        .REG_COUNT(REG_COUNT)
    ) u_reg_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    assign op_b = use_imm ? imm : rs2_data;

    alu u_alu (
        .a      (rs1_data),
        .b      (op_b),
        .alu_op (alu_op),
        .word_op(word_op),
        .result (alu_result)
    );

    // Write back on the same edge as the output registers
    assign wr_en   = inst_valid && !illegal_inst;
    assign wr_idx  = rd_idx;
    assign wr_data = alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            illegal      <= 1'b0;
            result_rd    <= '0;
            result       <= '0;
        end else begin
            result_valid <= inst_valid && !illegal_inst;
            illegal      <= inst_valid && illegal_inst;
            // Illegal instructions leave rd and result as they were
            if (wr_en) begin
                result_rd <= rd_idx;
                result    <= alu_result;
            end
        end
    end

endmodule

// File: rv_exec_asserts.sv
`timescale 1ns/1ns

module rv_exec_asserts (
    input logic clk,
    input logic arst_n,
    input logic inst_valid,
    input logic result_valid,
    input logic illegal
);

    // Strobes are mutually exclusive
    property strobes_exclusive;
        @(posedge clk) disable iff (!arst_n) !(result_valid && illegal);
    endproperty

    // One strobe in the cycle after each accepted instruction
    property strobe_follows_inst;
        @(posedge clk) disable iff (!arst_n) (result_valid || illegal) == $past(inst_valid);
    endproperty

    property idle_after_reset;
        @(posedge clk) $rose(arst_n) |-> !result_valid && !illegal;
    endproperty

    assert property (strobes_exclusive) else $error("result_valid and illegal both high");
    assert property (strobe_follows_inst) else $error("output strobe does not match inst_valid");
    assert property (idle_after_reset) else $error("output strobe high after reset");

endmodule

bind rv_exec_unit rv_exec_asserts u_rv_exec_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst_valid  (inst_valid),
    .result_valid(result_valid),
    .illegal     (illegal)
);

// File: tb_rv_exec_unit.sv
`timescale 1ns/1ns

module tb_rv_exec_unit;
    import rv_isa_pkg::*;
    import exec_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int CLK_HALF = 20;

    logic              clk;
    logic              arst_n;
    logic              inst_valid;
    logic [INST_W-1:0] inst;
    logic              result_valid;
    logic              illegal;
    logic [4:0]        result_rd;
    logic [XLEN-1:0]   result;

    logic [INST_W-1:0] inst_mem [MAX_LINES];
    logic              ill_mem  [MAX_LINES];
    int                rd_mem   [MAX_LINES];
    logic [XLEN-1:0]   res_mem  [MAX_LINES];
    int                gap_mem  [MAX_LINES];

    int   n_lines;
    int   errors;
    int   checked;
    int   cur_idx;
    int   exp_idx;
    logic exp_valid;
    logic any_issued;
    logic loaded;

    rv_exec_unit #(
        .REG_COUNT(32)
    ) u_rv_exec_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .result_valid(result_valid),
        .illegal     (illegal),
        .result_rd   (result_rd),
        .result      (result)
    );

    always #CLK_HALF clk = ~clk;

    task automatic read_stimulus();
        int    fd;
        int    code;
        string line;
        fd = $fopen("exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open exec_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                code = $fgets(line, fd);
                // Skip blank and comment lines
                if (code > 1 && line.getc(0) != 8'h23) begin
                    code = $sscanf(line, "%h %d %d %h %d", inst_mem[n_lines],
                                   ill_mem[n_lines], rd_mem[n_lines],
                                   res_mem[n_lines], gap_mem[n_lines]);
                    if (code == 5) begin
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // DUT samples the driven values on this edge
    always @(posedge clk) begin
        exp_valid <= inst_valid;
        exp_idx   <= cur_idx;
    end

    always @(negedge clk) begin
        if (arst_n && loaded) begin
            if (exp_valid) begin
                checked++;
                compare_value("result_valid", 64'(result_valid), 64'(!ill_mem[exp_idx]));
                compare_value("illegal", 64'(illegal), 64'(ill_mem[exp_idx]));
                compare_value("result_rd", 64'(result_rd), 64'(rd_mem[exp_idx]));
                compare_value("result", result, res_mem[exp_idx]);
            end else begin
                compare_value("result_valid", 64'(result_valid), 64'd0);
                compare_value("illegal", 64'(illegal), 64'd0);
                if (!any_issued) begin
                    compare_value("result_rd", 64'(result_rd), 64'd0);
                    compare_value("result", result, 64'd0);
                end
            end
        end
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        n_lines    = 0;
        errors     = 0;
        checked    = 0;
        cur_idx    = 0;
        exp_idx    = 0;
        exp_valid  = 1'b0;
        any_issued = 1'b0;
        loaded     = 1'b0;
        read_stimulus();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < n_lines; i++) begin
            repeat (gap_mem[i]) begin
                inst_valid <= 1'b0;
                inst       <= '0;
                @(posedge clk);
            end
            inst_valid <= 1'b1;
            inst       <= inst_mem[i];
            cur_idx    <= i;
            any_issued <= 1'b1;
            @(posedge clk);
        end
        inst_valid <= 1'b0;
        inst       <= '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (checked == n_lines) else begin
            $display("only %0d of %0d instructions were checked", checked, n_lines);
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat (n_lines * 3 + 20) @(posedge clk);
        $display("timeout, the run did not reach its end in time");
        $display("test failed");
        $finish;
    end

endmodule

// File: exec_stimulus.txt
# inst(hex) illegal rd(dec) result(hex) idle_cycles_before
# illegal lines expect rd and result held from the last legal one
800000b7 0 1 ffffffff80000000 0
fff08093 0 1 ffffffff7fffffff 0
12345137 0 2 0000000012345000 0
67810113 0 2 0000000012345678 0
ff800193 0 3 fffffffffffffff8 1
00300213 0 4 0000000000000003 0
004102b3 0 5 000000001234567b 0
40320333 0 6 000000000000000b 0
0041a3b3 0 7 0000000000000001 0
0041b433 0 8 0000000000000000 0
003144b3 0 9 ffffffffedcba980 0
00416533 0 10 000000001234567b 0
003175b3 0 11 0000000012345678 0
00411633 0 12 0000000091a2b3c0 0
4041d6b3 0 13 ffffffffffffffff 0
0041d733 0 14 1fffffffffffffff 0
4040d793 0 15 fffffffff7ffffff 0
fff1a813 0 16 0000000000000001 0
fff23893 0 17 0000000000000001 0
02821913 0 18 0000030000000000 0
fff14993 0 19 ffffffffedcba987 0
00408a3b 0 20 ffffffff80000002 0
40400abb 0 21 fffffffffffffffd 0
00411b3b 0 22 ffffffff91a2b3c0 0
0041dbbb 0 23 000000001fffffff 0
4040dc3b 0 24 000000000fffffff 0
00108c9b 0 25 ffffffff80000000 0
404b5d1b 0 26 fffffffff91a2b3c 0
00510013 0 0 000000001234567d 0
00000db3 0 27 0000000000000000 1
05500e13 0 28 0000000000000055 0
00001e17 1 28 0000000000000055 0
00000e6f 1 28 0000000000000055 0
00000063 1 28 0000000000000055 1
00003e03 1 28 0000000000000055 0
40004e33 1 28 0000000000000055 0
02410e33 1 28 0000000000000055 1
000e0e93 0 29 0000000000000055 0

// File: filelist.f
rv_isa_pkg.sv
exec_pkg.sv
rv_decoder.sv
alu.sv
reg_file.sv
rv_exec_unit.sv
rv_exec_asserts.sv
tb_rv_exec_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tb_rv_exec_unit
out=$(./obj_dir/Vtb_rv_exec_unit)
echo "$out"
if echo "$out" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi
